// File: vlog.f
+incdir+hdl
hdl/tap_pkg.sv
hdl/tap_fsm.sv
hdl/tap_ir.sv
hdl/tap_shift_reg.sv
hdl/tap_data_regs.sv
hdl/tap_tdo_mux.sv
hdl/tap_top.sv
verif/tap_tb.sv

// File: Bender.yml
package:
  name: jtag_tap

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/tap_pkg.sv
      - hdl/tap_fsm.sv
      - hdl/tap_ir.sv
      - hdl/tap_shift_reg.sv
      - hdl/tap_data_regs.sv
      - hdl/tap_tdo_mux.sv
      - hdl/tap_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/tap_tb.sv

// File: verif/tap_tb.sv
`timescale 1ns/1ps
`include "tap_settings.svh"

module tap_tb;
  import tap_pkg::*;

  localparam int CLK_PERIOD     = 4;
  localparam int PLANNED_CYCLES = 500;   // Scans, walks and resets added up

  logic tck_pad_i, trstn_pad_i, tms_pad_i, tdi_pad_i, debug_tdo_i;
  logic tdo_pad_o, tdo_padoe_o, test_logic_reset_o, run_test_idle_o;
  logic capture_dr_o, shift_dr_o, update_dr_o, debug_select_o, tdi_o;

  int          errors;
  int          checks;
  logic [31:0] rng;                   // xorshift state
  tap_state_e  model_st;              // Reference FSM state
  ir_t         model_ir;              // Reference active instruction
  ir_t         ir_sh;                 // Reference IR scan stage
  logic        tms_s, tdi_s, trst_s;  // Pins as seen by the next rising edge

  tap_top dut0 (
    .tck_pad_i         (tck_pad_i),
    .trstn_pad_i       (trstn_pad_i),
    .tms_pad_i         (tms_pad_i),
    .tdi_pad_i         (tdi_pad_i),
    .debug_tdo_i       (debug_tdo_i),
    .tdo_pad_o         (tdo_pad_o),
    .tdo_padoe_o       (tdo_padoe_o),
    .test_logic_reset_o(test_logic_reset_o),
    .run_test_idle_o   (run_test_idle_o),
    .capture_dr_o      (capture_dr_o),
    .shift_dr_o        (shift_dr_o),
    .update_dr_o       (update_dr_o),
    .debug_select_o    (debug_select_o),
    .tdi_o             (tdi_o)
  );

  always #(CLK_PERIOD/2) tck_pad_i = ~tck_pad_i;

  // IEEE 1149.1 state diagram, grouped by TMS level
  function automatic tap_state_e next_state(input tap_state_e s, input logic tms);
    tap_state_e n;
    if (tms)
      case (s)
        ST_RTI, ST_UPDR, ST_UPIR: n = ST_SELDR;
        ST_SELDR:                 n = ST_SELIR;
        ST_CAPDR, ST_SHDR:        n = ST_EX1DR;
        ST_EX1DR, ST_EX2DR:       n = ST_UPDR;
        ST_PDR:                   n = ST_EX2DR;
        ST_CAPIR, ST_SHIR:        n = ST_EX1IR;
        ST_EX1IR, ST_EX2IR:       n = ST_UPIR;
        ST_PIR:                   n = ST_EX2IR;
        default:                  n = ST_TLR;   // TLR and Select-IR
      endcase
    else
      case (s)
        ST_SELDR:                  n = ST_CAPDR;
        ST_CAPDR, ST_SHDR, ST_EX2DR: n = ST_SHDR;
        ST_EX1DR, ST_PDR:          n = ST_PDR;
        ST_SELIR:                  n = ST_CAPIR;
        ST_CAPIR, ST_SHIR, ST_EX2IR: n = ST_SHIR;
        ST_EX1IR, ST_PIR:          n = ST_PIR;
        default:                   n = ST_RTI;  // TLR, RTI and both Updates
      endcase
    return n;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // Values apply from this edge, sampled by the next one
  task automatic drive_pins(input logic tms, input logic tdi, input logic dbg);
    @(posedge tck_pad_i);
    tms_pad_i   <= tms;
    tdi_pad_i   <= tdi;
    debug_tdo_i <= dbg;
  endtask

  task automatic apply_reset();
    trstn_pad_i <= 1'b0;
    tms_pad_i   <= 1'b1;
    repeat (3) @(posedge tck_pad_i);
    trstn_pad_i <= 1'b1;
    tms_pad_i   <= 1'b0;    // Heads for Run-Test/Idle
  endtask

  // Five TMS highs from wherever the walk left the FSM
  task automatic reset_by_tms();
    repeat (5) drive_pins(1'b1, 1'b0, 1'b0);
    @(posedge tck_pad_i);
    #1;
    compare_value("test_logic_reset_o", 1'b1, test_logic_reset_o);
    drive_pins(1'b0, 1'b0, 1'b0);
  endtask

  // Starts and ends in Run-Test/Idle, TDO collected LSB first
  task automatic scan_chain(input logic is_ir, input int n, input logic [31:0] din,
                            input logic [31:0] dbg, output logic [31:0] dout);
    dout = '0;
    drive_pins(1'b1, 1'b0, 1'b0);
    if (is_ir)
      drive_pins(1'b1, 1'b0, 1'b0);   // On to Select-IR
    drive_pins(1'b0, 1'b0, 1'b0);     // Into Capture
    drive_pins(1'b0, 1'b0, 1'b0);     // Into Shift
    for (int i = 0; i < n; i++)
    begin
      @(posedge tck_pad_i);
      if (i > 0)
        dout[i-1] = tdo_pad_o;        // Bit shown during the previous Shift cycle
      tms_pad_i   <= (i == n - 1);
      tdi_pad_i   <= din[i];
      debug_tdo_i <= dbg[i];
    end
    @(posedge tck_pad_i);
    dout[n-1] = tdo_pad_o;
    tms_pad_i <= 1'b1;                // Exit1 to Update
    tdi_pad_i <= 1'b0;
    drive_pins(1'b0, 1'b0, 1'b0);
  endtask

  task automatic load_instruction(input ir_t op);
    logic [31:0] dout;
    scan_chain(1'b1, `TAP_IR_LENGTH, 32'(op), '0, dout);
    compare_value("tdo_pad_o", `TAP_IR_CAPTURE, dout);
  endtask

  task automatic dr_scan_check(input int n, input logic [31:0] din,
                               input logic [31:0] dbg, input logic [31:0] exp);
    logic [31:0] dout;
    logic [31:0] mask;
    mask = (n >= 32) ? 32'hFFFF_FFFF : ((32'd1 << n) - 1);
    scan_chain(1'b0, n, din, dbg, dout);
    compare_value("tdo_pad_o", exp & mask, dout);
  endtask

  always @(negedge tck_pad_i)
  begin
    tms_s  = tms_pad_i;
    tdi_s  = tdi_pad_i;
    trst_s = trstn_pad_i;
  end

  // Reference model steps each edge, outputs checked 1 ns later
  always
  begin : compare_proc
    tap_state_e old_st;
    logic       exp_oe;
    @(posedge tck_pad_i);
    #1;
    old_st = model_st;
    if (!trstn_pad_i || !trst_s)
      model_st = ST_TLR;
    else
      model_st = next_state(model_st, tms_s);
    if (!trstn_pad_i || old_st == ST_TLR)
      model_ir = `TAP_OP_IDCODE;
    else if (old_st == ST_UPIR)
      model_ir = ir_sh;               // Latched mid Update-IR
    if (old_st == ST_CAPIR)
      ir_sh = `TAP_IR_CAPTURE;
    else if (old_st == ST_SHIR)
      ir_sh = {tdi_s, ir_sh[`TAP_IR_LENGTH-1:1]};
    exp_oe = trstn_pad_i && (old_st == ST_SHDR || old_st == ST_SHIR);
    compare_value("test_logic_reset_o", model_st == ST_TLR, test_logic_reset_o);
    compare_value("run_test_idle_o", model_st == ST_RTI, run_test_idle_o);
    compare_value("capture_dr_o", model_st == ST_CAPDR, capture_dr_o);
    compare_value("shift_dr_o", model_st == ST_SHDR, shift_dr_o);
    compare_value("update_dr_o", model_st == ST_UPDR, update_dr_o);
    compare_value("tdo_padoe_o", exp_oe, tdo_padoe_o);
    compare_value("debug_select_o", model_ir == `TAP_OP_DEBUG, debug_select_o);
    compare_value("tdi_o", tdi_pad_i, tdi_o);
  end

  initial
  begin : watchdog
    #(2 * PLANNED_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d ns", 2 * PLANNED_CYCLES * CLK_PERIOD);
    $display("Errors: %0d in %0d checks", errors, checks);
    $display("Test failures found");
    $finish;
  end

  initial
  begin : main_seq
    logic [31:0] din;
    logic [31:0] dbg;
    tck_pad_i   = 1'b0;
    trstn_pad_i = 1'b0;
    tms_pad_i   = 1'b1;
    tdi_pad_i   = 1'b0;
    debug_tdo_i = 1'b0;
    errors      = 0;
    checks      = 0;
    rng         = 32'd6560;
    model_st    = ST_TLR;
    model_ir    = `TAP_OP_IDCODE;
    ir_sh       = '0;
    trst_s      = 1'b0;
    apply_reset();
    rng = xorshift32(rng);
    dr_scan_check(32, rng, '0, `TAP_IDCODE_VALUE);   // IDCODE out of reset
    load_instruction(`TAP_OP_BYPASS);
    rng = xorshift32(rng);
    din = rng;
    dr_scan_check(16, din, '0, {din[30:0], 1'b0});  // Zero, then TDI one bit late
    load_instruction(4'b0000);                       // Old EXTEST opcode
    rng = xorshift32(rng);
    din = rng;
    dr_scan_check(20, din, '0, {din[30:0], 1'b0});
    load_instruction(`TAP_OP_DEBUG);
    rng = xorshift32(rng);
    din = rng;
    rng = xorshift32(rng);
    dbg = rng;
    dr_scan_check(24, din, dbg, dbg);                // External chain straight to TDO
    reset_by_tms();
    dr_scan_check(32, din, '0, `TAP_IDCODE_VALUE);
    repeat (6)
    begin
      repeat (24)
      begin
        rng = xorshift32(rng);
        drive_pins(rng[0], rng[1], rng[2]);
      end
      reset_by_tms();
    end
    load_instruction(`TAP_OP_BYPASS);
    drive_pins(1'b0, 1'b0, 1'b0);                    // Update-IR latches BYPASS
    apply_reset();
    dr_scan_check(32, rng, '0, `TAP_IDCODE_VALUE);
    $display("Errors: %0d in %0d checks", errors, checks);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: hdl/tap_top.sv
`timescale 1ns/1ps

module tap_top (
  input  logic tck_pad_i,
  input  logic trstn_pad_i,
  input  logic tms_pad_i,
  input  logic tdi_pad_i,
  input  logic debug_tdo_i,        // Return from the debug chain
  output logic tdo_pad_o,
  output logic tdo_padoe_o,
  output logic test_logic_reset_o,
  output logic run_test_idle_o,
  output logic capture_dr_o,
  output logic shift_dr_o,
  output logic update_dr_o,
  output logic debug_select_o,
  output logic tdi_o               // Feeds the debug chain TDI
);
  import tap_pkg::*;

  logic    tlr;
  logic    capture_dr, shift_dr;
  logic    capture_ir, shift_ir, update_ir;
  logic    ir_tdo;
  logic    idcode_tdo, bypass_tdo;
  dr_sel_e dr_sel;

  tap_fsm u_fsm (
    .tck_pad_i   (tck_pad_i),
    .trstn_pad_i (trstn_pad_i),
    .tms_pad_i   (tms_pad_i),
    .tlr_o       (tlr),
    .rti_o       (run_test_idle_o),
    .capture_dr_o(capture_dr),
    .shift_dr_o  (shift_dr),
    .update_dr_o (update_dr_o),
    .capture_ir_o(capture_ir),
    .shift_ir_o  (shift_ir),
    .update_ir_o (update_ir)
  );

  tap_ir u_ir (
    .tck_pad_i   (tck_pad_i),
    .trstn_pad_i (trstn_pad_i),
    .tdi_i       (tdi_pad_i),
    .tlr_i       (tlr),
    .capture_ir_i(capture_ir),
    .shift_ir_i  (shift_ir),
    .update_ir_i (update_ir),
    .ir_tdo_o    (ir_tdo),
    .dr_sel_o    (dr_sel)
  );

  tap_data_regs u_data_regs (
    .tck_pad_i   (tck_pad_i),
    .trstn_pad_i (trstn_pad_i),
    .tdi_i       (tdi_pad_i),
    .tlr_i       (tlr),
    .capture_dr_i(capture_dr),
    .shift_dr_i  (shift_dr),
    .dr_sel_i    (dr_sel),
    .idcode_tdo_o(idcode_tdo),
    .bypass_tdo_o(bypass_tdo)
  );

  tap_tdo_mux u_tdo_mux (
    .tck_pad_i   (tck_pad_i),
    .trstn_pad_i (trstn_pad_i),
    .shift_ir_i  (shift_ir),
    .shift_dr_i  (shift_dr),
    .ir_tdo_i    (ir_tdo),
    .idcode_tdo_i(idcode_tdo),
    .bypass_tdo_i(bypass_tdo),
    .debug_tdo_i (debug_tdo_i),
    .dr_sel_i    (dr_sel),
    .tdo_pad_o   (tdo_pad_o),
    .tdo_padoe_o (tdo_padoe_o)
  );

  // Pad side views of the internal enables
  assign test_logic_reset_o = tlr;
  assign capture_dr_o       = capture_dr;
  assign shift_dr_o         = shift_dr;
  assign debug_select_o     = (dr_sel == SEL_DEBUG);  // Same select the mux uses
  assign tdi_o              = tdi_pad_i;

endmodule

// File: hdl/tap_tdo_mux.sv
`timescale 1ns/1ps

module tap_tdo_mux (
  input  logic             tck_pad_i,
  input  logic             trstn_pad_i,
  input  logic             shift_ir_i,
  input  logic             shift_dr_i,
  input  logic             ir_tdo_i,
  input  logic             idcode_tdo_i,
  input  logic             bypass_tdo_i,
  input  logic             debug_tdo_i,   // External debug chain
  input  tap_pkg::dr_sel_e dr_sel_i,
  output logic             tdo_pad_o,
  output logic             tdo_padoe_o
);
  import tap_pkg::*;

  logic tdo_mux;

  // IR wins during Shift-IR, else the selected DR
  always_comb
  begin
    if (shift_ir_i)
      tdo_mux = ir_tdo_i;
    else
    begin
      case (dr_sel_i)
        SEL_IDCODE: tdo_mux = idcode_tdo_i;
        SEL_DEBUG:  tdo_mux = debug_tdo_i;
        default:    tdo_mux = bypass_tdo_i;
      endcase
    end
  end

  // TDO moves on the falling edge
  always_ff @(negedge tck_pad_i or negedge trstn_pad_i)
  begin
    if (!trstn_pad_i)
      tdo_pad_o <= 1'b0;
    else
      tdo_pad_o <= tdo_mux;
  end

  // Pad driven only while shifting
  always_ff @(posedge tck_pad_i or negedge trstn_pad_i)
  begin
    if (!trstn_pad_i)
      tdo_padoe_o <= 1'b0;
    else
      tdo_padoe_o <= shift_ir_i | shift_dr_i;
  end

endmodule

// File: hdl/tap_data_regs.sv
`timescale 1ns/1ps
`include "tap_settings.svh"

module tap_data_regs (
  input  logic             tck_pad_i,
  input  logic             trstn_pad_i,
  input  logic             tdi_i,
  input  logic             tlr_i,
  input  logic             capture_dr_i,
  input  logic             shift_dr_i,
  input  tap_pkg::dr_sel_e dr_sel_i,
  output logic             idcode_tdo_o,
  output logic             bypass_tdo_o
);
  import tap_pkg::*;

  localparam idcode_t IDCODE_VAL = `TAP_IDCODE_VALUE;
  localparam bypass_t BYPASS_VAL = '0;   // Capture-DR loads a zero

  logic idcode_sel;
  logic bypass_sel;

  // Only the selected register sees the DR enables
  assign idcode_sel = (dr_sel_i == SEL_IDCODE);
  assign bypass_sel = (dr_sel_i == SEL_BYPASS);

  tap_shift_reg #(.payload_t(idcode_t)) u_idcode (
    .tck_pad_i    (tck_pad_i),
    .trstn_pad_i  (trstn_pad_i),
    .tdi_i        (tdi_i),
    .clear_i      (tlr_i),
    .capture_i    (capture_dr_i & idcode_sel),
    .shift_i      (shift_dr_i & idcode_sel),
    .capture_val_i(IDCODE_VAL),
    .tdo_o        (idcode_tdo_o)
  );

  tap_shift_reg #(.payload_t(bypass_t)) u_bypass (
    .tck_pad_i    (tck_pad_i),
    .trstn_pad_i  (trstn_pad_i),
    .tdi_i        (tdi_i),
    .clear_i      (tlr_i),
    .capture_i    (capture_dr_i & bypass_sel),
    .shift_i      (shift_dr_i & bypass_sel),   // One bit delay TDI to TDO
    .capture_val_i(BYPASS_VAL),
    .tdo_o        (bypass_tdo_o)
  );

endmodule

// File: hdl/tap_shift_reg.sv
`timescale 1ns/1ps

module tap_shift_reg #(
  parameter type payload_t = tap_pkg::bypass_t
) (
  input  logic     tck_pad_i,
  input  logic     trstn_pad_i,
  input  logic     tdi_i,
  input  logic     clear_i,        // Test-Logic-Reset
  input  logic     capture_i,
  input  logic     shift_i,
  input  payload_t capture_val_i,  // Parallel load value
  output logic     tdo_o
);
  localparam int W = $bits(payload_t);

  payload_t   shift_q;
  logic [W:0] shift_next;   // TDI on top, one spare bit falls off

  assign shift_next = {tdi_i, shift_q};

  always_ff @(posedge tck_pad_i or negedge trstn_pad_i)
  begin
    if (!trstn_pad_i)
      shift_q <= capture_val_i;
    else if (clear_i || capture_i)
      shift_q <= capture_val_i;
    else if (shift_i)
      shift_q <= shift_next[W:1];   // Also fine for a single bit
  end

  assign tdo_o = shift_q[0];   // LSB leaves first

  a_no_capture_while_shift: assert property (
    @(posedge tck_pad_i) disable iff (!trstn_pad_i)
    !(capture_i && shift_i)
  ) else $error("Capture and shift requested together");

endmodule

// File: hdl/tap_ir.sv
`timescale 1ns/1ps
`include "tap_settings.svh"

module tap_ir (
  input  logic             tck_pad_i,
  input  logic             trstn_pad_i,
  input  logic             tdi_i,
  input  logic             tlr_i,
  input  logic             capture_ir_i,
  input  logic             shift_ir_i,
  input  logic             update_ir_i,
  output logic             ir_tdo_o,    // Sampled by the TDO mux on the falling edge
  output tap_pkg::dr_sel_e dr_sel_o
);
  import tap_pkg::*;

  ir_t shift_q;     // Scan stage
  ir_t latched_q;   // Active instruction

  // Capture and shift on the rising edge
  always_ff @(posedge tck_pad_i or negedge trstn_pad_i)
  begin
    if (!trstn_pad_i)
      shift_q <= '0;
    else if (tlr_i)
      shift_q <= '0;
    else if (capture_ir_i)
      shift_q <= `TAP_IR_CAPTURE;
    else if (shift_ir_i)
      shift_q <= {tdi_i, shift_q[`TAP_IR_LENGTH-1:1]};  // LSB out first
  end

  assign ir_tdo_o = shift_q[0];

  // New instruction takes effect mid Update-IR
  always_ff @(negedge tck_pad_i or negedge trstn_pad_i)
  begin
    if (!trstn_pad_i)
      latched_q <= `TAP_OP_IDCODE;  // IDCODE after reset
    else if (tlr_i)
      latched_q <= `TAP_OP_IDCODE;
    else if (update_ir_i)
      latched_q <= shift_q;
  end

  // Instruction decode
  always_comb
  begin
    case (latched_q)
      `TAP_OP_IDCODE: dr_sel_o = SEL_IDCODE;
      `TAP_OP_DEBUG:  dr_sel_o = SEL_DEBUG;
      `TAP_OP_BYPASS: dr_sel_o = SEL_BYPASS;
      default:        dr_sel_o = SEL_BYPASS;  // Former EXTEST, SAMPLE and MBIST land here
    endcase
  end

  a_dr_sel_known: assert property (
    @(posedge tck_pad_i) disable iff (!trstn_pad_i)
    !$isunknown(dr_sel_o)
  ) else $error("Data register select is unknown");

endmodule

// File: hdl/tap_fsm.sv
`timescale 1ns/1ps

module tap_fsm (
  input  logic tck_pad_i,
  input  logic trstn_pad_i,
  input  logic tms_pad_i,
  output logic tlr_o,         // Test-Logic-Reset
  output logic rti_o,         // Run-Test/Idle
  output logic capture_dr_o,
  output logic shift_dr_o,
  output logic update_dr_o,
  output logic capture_ir_o,
  output logic shift_ir_o,
  output logic update_ir_o
);
  import tap_pkg::*;

  tap_state_e state_q;
  tap_state_e state_d;

  // State register, reset parks in TLR
  always_ff @(posedge tck_pad_i or negedge trstn_pad_i)
  begin
    if (!trstn_pad_i)
      state_q <= ST_TLR;
    else
      state_q <= state_d;
  end

  // Standard 1149.1 transitions
  always_comb
  begin
    case (state_q)
      ST_TLR:   state_d = tms_pad_i ? ST_TLR   : ST_RTI;
      ST_RTI:   state_d = tms_pad_i ? ST_SELDR : ST_RTI;
      ST_SELDR: state_d = tms_pad_i ? ST_SELIR : ST_CAPDR;
      ST_CAPDR: state_d = tms_pad_i ? ST_EX1DR : ST_SHDR;
      ST_SHDR:  state_d = tms_pad_i ? ST_EX1DR : ST_SHDR;
      ST_EX1DR: state_d = tms_pad_i ? ST_UPDR  : ST_PDR;
      ST_PDR:   state_d = tms_pad_i ? ST_EX2DR : ST_PDR;
      ST_EX2DR: state_d = tms_pad_i ? ST_UPDR  : ST_SHDR;
      ST_UPDR:  state_d = tms_pad_i ? ST_SELDR : ST_RTI;
      ST_SELIR: state_d = tms_pad_i ? ST_TLR   : ST_CAPIR;  // Third TMS high toward reset
      ST_CAPIR: state_d = tms_pad_i ? ST_EX1IR : ST_SHIR;
      ST_SHIR:  state_d = tms_pad_i ? ST_EX1IR : ST_SHIR;
      ST_EX1IR: state_d = tms_pad_i ? ST_UPIR  : ST_PIR;
      ST_PIR:   state_d = tms_pad_i ? ST_EX2IR : ST_PIR;
      ST_EX2IR: state_d = tms_pad_i ? ST_UPIR  : ST_SHIR;
      ST_UPIR:  state_d = tms_pad_i ? ST_SELDR : ST_RTI;
      default:  state_d = ST_TLR;   // Unreachable with a full enum
    endcase
  end

  // Enables straight from the state register
  assign tlr_o        = (state_q == ST_TLR);
  assign rti_o        = (state_q == ST_RTI);
  assign capture_dr_o = (state_q == ST_CAPDR);
  assign shift_dr_o   = (state_q == ST_SHDR);
  assign update_dr_o  = (state_q == ST_UPDR);
  assign capture_ir_o = (state_q == ST_CAPIR);
  assign shift_ir_o   = (state_q == ST_SHIR);
  assign update_ir_o  = (state_q == ST_UPIR);

  // Enables are mutually exclusive, checked on every edge
  a_enables_onehot0: assert property (
    @(posedge tck_pad_i) disable iff (!trstn_pad_i)
    $onehot0({tlr_o, rti_o, capture_dr_o, shift_dr_o, update_dr_o,
              capture_ir_o, shift_ir_o, update_ir_o})
  ) else $error("More than one TAP state enable active");

endmodule

// File: hdl/tap_pkg.sv
`include "tap_settings.svh"

package tap_pkg;

  // Binary state encoding, four flops
  typedef enum logic [3:0] {
    ST_TLR   = 4'hF,  // Test-Logic-Reset
    ST_RTI   = 4'hC,  // Run-Test/Idle
    ST_SELDR = 4'h7,
    ST_CAPDR = 4'h6,
    ST_SHDR  = 4'h2,
    ST_EX1DR = 4'h1,
    ST_PDR   = 4'h3,
    ST_EX2DR = 4'h0,
    ST_UPDR  = 4'h5,
    ST_SELIR = 4'h4,
    ST_CAPIR = 4'hE,
    ST_SHIR  = 4'hA,
    ST_EX1IR = 4'h9,
    ST_PIR   = 4'hB,
    ST_EX2IR = 4'h8,
    ST_UPIR  = 4'hD
  } tap_state_e;

  // Register payloads
  typedef logic [`TAP_IR_LENGTH-1:0]     ir_t;
  typedef logic [`TAP_IDCODE_LENGTH-1:0] idcode_t;
  typedef logic [0:0]                    bypass_t;

  // Which data register sits between TDI and TDO
  typedef enum logic [1:0] {
    SEL_IDCODE,
    SEL_DEBUG,
    SEL_BYPASS
  } dr_sel_e;

endpackage

// File: hdl/tap_settings.svh
`ifndef TAP_SETTINGS_SVH
`define TAP_SETTINGS_SVH

// Instruction register
`define TAP_IR_LENGTH     4
`define TAP_IR_CAPTURE    4'b0101   // Fixed pattern for fault detection

// Opcodes, anything else selects BYPASS
`define TAP_OP_IDCODE     4'b0010
`define TAP_OP_DEBUG      4'b1000
`define TAP_OP_BYPASS     4'b1111

// Device identification
`define TAP_IDCODE_LENGTH 32
`define TAP_IDCODE_VALUE  32'h149511c3  // Version, part number, manufacturer, marker bit

`endif
